// File: include/ifid_config.svh
// widths for the IF/ID decode front end
// opcode, operand and target fields are all carved from one 16-bit word
// integer register file only, so operand addresses are 3 bits
`ifndef IFID_CONFIG_SVH
`define IFID_CONFIG_SVH

//////////////////////////////////////////////////
// instruction word
//////////////////////////////////////////////////

// full instruction from instruction memory
`define IFID_INSTR_W 16

// opcode lives in bits 15..11
`define IFID_OPC_W 5

//////////////////////////////////////////////////
// register file and datapath
//////////////////////////////////////////////////

// 8 integer registers
`define IFID_REG_AW 3

// operand data width, one byte
`define IFID_DATA_W 8

// branch target, instruction bits 9..0
`define IFID_PC_W 10

`endif

// File: design/ifid_pkg.sv
// types shared by the decoder, the stage registers and the top
// opcode encodings of the 8-bit core where unlisted codes decode as NOP
// RNS opcodes 19..25 are not decoded and fall through to NOP
`default_nettype none

`include "ifid_config.svh"

package ifid_pkg;

    //////////////////////////////////////////////////
    // opcodes
    //////////////////////////////////////////////////
    typedef enum logic [`IFID_OPC_W-1:0] {
        op_nop     = `IFID_OPC_W'd0,
        op_add     = `IFID_OPC_W'd1,
        op_sub     = `IFID_OPC_W'd2,
        op_and     = `IFID_OPC_W'd3,
        op_or      = `IFID_OPC_W'd4,
        op_not     = `IFID_OPC_W'd5,
        op_shl     = `IFID_OPC_W'd6,
        op_jmp     = `IFID_OPC_W'd7,
        op_rload   = `IFID_OPC_W'd8,   // rd <- mem[{op2, op1}]
        op_rstore  = `IFID_OPC_W'd9,   // mem[{op2, op1}] <- res reg
        op_andbit  = `IFID_OPC_W'd10,
        op_orbit   = `IFID_OPC_W'd11,
        op_notbit  = `IFID_OPC_W'd12,
        op_compare = `IFID_OPC_W'd13,  // sub without writeback
        op_jmpgt   = `IFID_OPC_W'd14,
        op_jmplt   = `IFID_OPC_W'd15,
        op_jmpeq   = `IFID_OPC_W'd16,
        op_jmpc    = `IFID_OPC_W'd17,
        op_ldi     = `IFID_OPC_W'd18,  // rd <- imm
        op_output  = `IFID_OPC_W'd26,  // port <- res reg
        op_input   = `IFID_OPC_W'd27   // rd <- port
    } opcode_e;

    //////////////////////////////////////////////////
    // decoded control bundle of 45 bits
    //////////////////////////////////////////////////
    typedef struct packed {
        // alu
        logic add_op;
        logic and_op;
        logic or_op;
        logic not_op;
        logic and_bit;
        logic or_bit;
        logic not_bit;
        logic carry_in;          // +1 for two's complement subtract
        logic op2_complement;    // invert op2 into the adder
        logic shift_left;
        logic compare;
        logic logic_op;          // any logical or bitwise op
        // branches
        logic jump;
        logic jmp_uncond;
        logic jmp_gt;
        logic jmp_lt;
        logic jmp_eq;
        logic jmp_carry;
        // memory and io
        logic load;
        logic store;
        logic ld_imm;
        logic out_op;
        logic in_op;
        // writeback
        logic wr_en;
        logic [`IFID_REG_AW-1:0] dest;     // zero for rstore
        logic [`IFID_DATA_W-1:0] imm;      // instr[7:0], also io port
        logic [`IFID_PC_W-1:0]   target;   // instr[9:0]
    } ctrl_t;

    // register file read request with unread addresses at zero
    typedef struct packed {
        logic                    rd_en;
        logic [`IFID_REG_AW-1:0] op1_addr;
        logic [`IFID_REG_AW-1:0] op2_addr;
        logic [`IFID_REG_AW-1:0] op3_addr;
    } rd_req_t;

    // operand data plus the addresses it came from (33 bits)
    typedef struct packed {
        logic [`IFID_DATA_W-1:0] op1_data;
        logic [`IFID_DATA_W-1:0] op2_data;
        logic [`IFID_DATA_W-1:0] op3_data;
        logic [`IFID_REG_AW-1:0] op1_addr;
        logic [`IFID_REG_AW-1:0] op2_addr;
        logic [`IFID_REG_AW-1:0] op3_addr;
    } operand_t;

endpackage

`default_nettype wire

// File: design/ifid_decoder.sv
// purely combinational opcode decode, no clock
// instr bits 7 and 3 are don't-care for operand addresses
// unknown opcodes give an all-zero flag set and no register read
`default_nettype none

`include "ifid_config.svh"

module ifid_decoder (
    input  wire logic [`IFID_INSTR_W-1:0] instr,
    output ifid_pkg::ctrl_t               ctrl,
    output ifid_pkg::rd_req_t             rd_req
);

    //////////////////////////////////////////////////
    // field split
    //////////////////////////////////////////////////
    ifid_pkg::opcode_e       opcode;
    logic [`IFID_REG_AW-1:0] res_addr;   // dest, or source for rstore/output
    logic [`IFID_REG_AW-1:0] op2_addr;
    logic [`IFID_REG_AW-1:0] op1_addr;

    assign opcode   = ifid_pkg::opcode_e'(instr[15:11]);
    assign res_addr = instr[10:8];
    assign op2_addr = instr[6:4];       // bit 7 ignored
    assign op1_addr = instr[2:0];       // bit 3 likewise

    // which operands this opcode reads
    logic rd_ab;    // op1 and op2
    logic rd_c;     // op3 = res

    //////////////////////////////////////////////////
    // opcode decode
    //////////////////////////////////////////////////
    always_comb
    begin
        ctrl        = '0;
        ctrl.dest   = res_addr;
        ctrl.imm    = instr[7:0];               // ldi value or io port
        ctrl.target = instr[`IFID_PC_W-1:0];    // jump target
        rd_ab       = 1'b0;
        rd_c        = 1'b0;

        case (opcode)
            ifid_pkg::op_add:
            begin
                ctrl.add_op = 1'b1;
                ctrl.wr_en  = 1'b1;
                rd_ab       = 1'b1;
            end
            ifid_pkg::op_sub:
            begin
                ctrl.add_op         = 1'b1;
                ctrl.carry_in       = 1'b1;     // a + ~b + 1
                ctrl.op2_complement = 1'b1;
                ctrl.wr_en          = 1'b1;
                rd_ab               = 1'b1;
            end
            ifid_pkg::op_and:
            begin
                ctrl.and_op   = 1'b1;
                ctrl.logic_op = 1'b1;
                ctrl.wr_en    = 1'b1;
                rd_ab         = 1'b1;
            end
            ifid_pkg::op_or:
            begin
                ctrl.or_op    = 1'b1;
                ctrl.logic_op = 1'b1;
                ctrl.wr_en    = 1'b1;
                rd_ab         = 1'b1;
            end
            ifid_pkg::op_not:
            begin
                ctrl.not_op   = 1'b1;
                ctrl.logic_op = 1'b1;
                ctrl.wr_en    = 1'b1;
                rd_ab         = 1'b1;
            end
            ifid_pkg::op_shl:
            begin
                ctrl.shift_left = 1'b1;
                ctrl.wr_en      = 1'b1;
                rd_ab           = 1'b1;
            end
            ifid_pkg::op_andbit:
            begin
                ctrl.and_bit  = 1'b1;
                ctrl.logic_op = 1'b1;
                ctrl.wr_en    = 1'b1;
                rd_ab         = 1'b1;
            end
            ifid_pkg::op_orbit:
            begin
                ctrl.or_bit   = 1'b1;
                ctrl.logic_op = 1'b1;
                ctrl.wr_en    = 1'b1;
                rd_ab         = 1'b1;
            end
            ifid_pkg::op_notbit:
            begin
                ctrl.not_bit  = 1'b1;
                ctrl.logic_op = 1'b1;
                ctrl.wr_en    = 1'b1;
                rd_ab         = 1'b1;
            end
            ifid_pkg::op_compare:
            begin
                ctrl.add_op         = 1'b1;     // subtract for flags only
                ctrl.compare        = 1'b1;
                ctrl.carry_in       = 1'b1;
                ctrl.op2_complement = 1'b1;
                rd_ab               = 1'b1;
            end
            // branches read nothing since the condition comes from ex flags
            ifid_pkg::op_jmp:
            begin
                ctrl.jump       = 1'b1;
                ctrl.jmp_uncond = 1'b1;
            end
            ifid_pkg::op_jmpgt:
            begin
                ctrl.jump   = 1'b1;
                ctrl.jmp_gt = 1'b1;
            end
            ifid_pkg::op_jmplt:
            begin
                ctrl.jump   = 1'b1;
                ctrl.jmp_lt = 1'b1;
            end
            ifid_pkg::op_jmpeq:
            begin
                ctrl.jump   = 1'b1;
                ctrl.jmp_eq = 1'b1;
            end
            ifid_pkg::op_jmpc:
            begin
                ctrl.jump      = 1'b1;
                ctrl.jmp_carry = 1'b1;
            end
            ifid_pkg::op_rload:
            begin
                ctrl.load  = 1'b1;              // address in op2:op1 regs
                ctrl.wr_en = 1'b1;
                rd_ab      = 1'b1;
            end
            ifid_pkg::op_rstore:
            begin
                ctrl.store = 1'b1;
                ctrl.dest  = '0;                // res is a source here
                rd_ab      = 1'b1;
                rd_c       = 1'b1;
            end
            ifid_pkg::op_ldi:
            begin
                ctrl.ld_imm = 1'b1;
                ctrl.wr_en  = 1'b1;
            end
            ifid_pkg::op_output:
            begin
                ctrl.out_op = 1'b1;             // no writeback
                rd_c        = 1'b1;
            end
            ifid_pkg::op_input:
            begin
                ctrl.in_op = 1'b1;
                ctrl.wr_en = 1'b1;
            end
            default: ;                          // nop incl. rns codes 19..25
        endcase

        // addresses masked when not read
        rd_req.rd_en    = rd_ab | rd_c;
        rd_req.op1_addr = rd_ab ? op1_addr : '0;
        rd_req.op2_addr = rd_ab ? op2_addr : '0;
        rd_req.op3_addr = rd_c ? res_addr : '0;
    end

endmodule

`default_nettype wire

// File: design/ifid_stage_reg.sv
// one-deep pipeline register, never stalls
// squash loads an all-zero payload, which reads as a nop downstream
`default_nettype none

module ifid_stage_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic squash,     // branch taken in ex this cycle
    input  payload_t  d,
    output payload_t  q,
    output logic      squashed    // q holds a killed item
);

    //////////////////////////////////////////////////
    // capture
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            q        <= '0;
            squashed <= 1'b0;
        end
        else if (squash)
        begin
            q        <= '0;     // kill the wrong-path item
            squashed <= 1'b1;
        end
        else
        begin
            q        <= d;
            squashed <= 1'b0;
        end
    end

    // both outputs settle to zero together on reset, so a squashed
    // item and a reset item look the same to the payload consumer

endmodule

`default_nettype wire

// File: design/ifid_stage.sv
// IF/ID front end: decode in cycle 0, registered bundle in cycle 1
// rd_req and load_req are combinational strobes, rd_data is expected same cycle
// address fields of rd_data are ignored, the decoder's addresses are used
`default_nettype none

`include "ifid_config.svh"

module ifid_stage (
    input  wire logic [`IFID_INSTR_W-1:0] instr,
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     branch_taken_ex,  // level from ex
    input  ifid_pkg::operand_t            rd_data,          // data fields only
    output ifid_pkg::rd_req_t             rd_req,           // to regfile
    output logic                          load_req,         // to forwarding
    output ifid_pkg::ctrl_t               id_ctrl,
    output ifid_pkg::operand_t            id_opnd,
    output logic                          id_squash
);

    ifid_pkg::ctrl_t    dec_ctrl;
    ifid_pkg::operand_t opnd_d;

    //////////////////////////////////////////////////
    // decode, zero cycles
    //////////////////////////////////////////////////
    ifid_decoder u_dec (
        .instr  (instr),
        .ctrl   (dec_ctrl),
        .rd_req (rd_req)
    );

    assign load_req = dec_ctrl.load;    // rload seen early for hazards

    // operand payload: regfile data tagged with the addresses we asked for
    always_comb
    begin
        opnd_d.op1_data = rd_data.op1_data;
        opnd_d.op2_data = rd_data.op2_data;
        opnd_d.op3_data = rd_data.op3_data;
        opnd_d.op1_addr = rd_req.op1_addr;
        opnd_d.op2_addr = rd_req.op2_addr;
        opnd_d.op3_addr = rd_req.op3_addr;
    end

    //////////////////////////////////////////////////
    // stage registers, one cycle
    //////////////////////////////////////////////////
    ifid_stage_reg #(
        .payload_t (ifid_pkg::ctrl_t)
    ) u_ctrl_reg (
        .clk      (clk),
        .rst      (rst),
        .squash   (branch_taken_ex),
        .d        (dec_ctrl),
        .q        (id_ctrl),
        .squashed (id_squash)           // one flag is enough for the stage
    );

    // same squash, so its flag always equals id_squash
    ifid_stage_reg #(
        .payload_t (ifid_pkg::operand_t)
    ) u_opnd_reg (
        .clk      (clk),
        .rst      (rst),
        .squash   (branch_taken_ex),
        .d        (opnd_d),
        .q        (id_opnd),
        .squashed ()
    );

endmodule

`default_nettype wire

// File: dv/ifid_chk.sv
// properties on the IF/ID outputs, bound into ifid_stage
// reset is synchronous, the reset check starts after the first edge
`default_nettype none

module ifid_chk (
    input wire logic          clk,
    input wire logic          rst,
    input ifid_pkg::rd_req_t  rd_req,
    input ifid_pkg::ctrl_t    id_ctrl,
    input ifid_pkg::operand_t id_opnd,
    input wire logic          id_squash
);

    logic armed       = 1'b0;   // one edge seen, $past is valid
    logic fired_addr  = 1'b0;
    logic fired_sq    = 1'b0;
    logic fired_rst   = 1'b0;
    logic fired_store = 1'b0;
    logic any_fired;

    always @(posedge clk)
        armed <= 1'b1;

    assign any_fired = fired_addr | fired_sq | fired_rst | fired_store;

    //////////////////////////////////////////////////
    // properties
    //////////////////////////////////////////////////
    a_unread_zero: assert property (@(posedge clk) disable iff (rst)
        !rd_req.rd_en |-> (rd_req.op1_addr == '0 && rd_req.op2_addr == '0
                           && rd_req.op3_addr == '0))
    else
    begin
        fired_addr = 1'b1;
        $error("read address set while rd_en is low");
    end

    // a killed item is a plain nop
    a_squash_nop: assert property (@(posedge clk) disable iff (rst)
        id_squash |-> (id_ctrl == '0 && id_opnd == '0))
    else
    begin
        fired_sq = 1'b1;
        $error("squashed item carries a payload");
    end

    a_reset_zero: assert property (@(posedge clk)
        (armed && $past(rst)) |-> (id_ctrl == '0 && id_opnd == '0 && !id_squash))
    else
    begin
        fired_rst = 1'b1;
        $error("registered outputs not zero after a reset edge");
    end

    a_store_dest: assert property (@(posedge clk) disable iff (rst)
        id_ctrl.store |-> (id_ctrl.dest == '0))
    else
    begin
        fired_store = 1'b1;
        $error("rstore with a nonzero dest");
    end

endmodule

`default_nettype wire

// File: include/ifid_tb_model.svh
// reference decode for the testbench, built from the opcode table
// register file stub data is a fixed function of port and address
`ifndef IFID_TB_MODEL_SVH
`define IFID_TB_MODEL_SVH

`include "ifid_config.svh"

// stub contents, a different line per read port
function automatic logic [`IFID_DATA_W-1:0] regfile_word(input int port,
        input logic [`IFID_REG_AW-1:0] addr);
    logic [`IFID_DATA_W-1:0] a;
    a = '0;
    a[`IFID_REG_AW-1:0] = addr;
    case (port)
        1:       regfile_word = a * 8'd17 + 8'd3;
        2:       regfile_word = a * 8'd29 + 8'd5;
        default: regfile_word = a * 8'd41 + 8'd7;
    endcase
endfunction

// what the register file hands back, address fields left at zero
function automatic ifid_pkg::operand_t regfile_read(input ifid_pkg::rd_req_t q);
    ifid_pkg::operand_t d;
    d = '0;
    d.op1_data = regfile_word(1, q.op1_addr);
    d.op2_data = regfile_word(2, q.op2_addr);
    d.op3_data = regfile_word(3, q.op3_addr);
    return d;
endfunction

// registered operand payload: stub data tagged with the expected addresses
function automatic ifid_pkg::operand_t expected_operands(input ifid_pkg::rd_req_t q);
    ifid_pkg::operand_t d;
    d = regfile_read(q);
    d.op1_addr = q.op1_addr;
    d.op2_addr = q.op2_addr;
    d.op3_addr = q.op3_addr;
    return d;
endfunction

function automatic void model_decode(input logic [`IFID_INSTR_W-1:0] ins,
        output ifid_pkg::ctrl_t c, output ifid_pkg::rd_req_t q);
    int opc;
    bit alu;    // alu ops with writeback
    bit rd_ab;
    bit rd_c;
    opc   = int'(ins[15:11]);
    alu   = (opc inside {1, 2, 3, 4, 5, 6, 10, 11, 12});
    rd_ab = alu || (opc inside {8, 9, 13});     // + rload, rstore, compare
    rd_c  = (opc inside {9, 26});               // rstore and output read res
    c = '0;
    c.add_op         = (opc inside {1, 2, 13});
    c.and_op         = (opc == 3);
    c.or_op          = (opc == 4);
    c.not_op         = (opc == 5);
    c.and_bit        = (opc == 10);
    c.or_bit         = (opc == 11);
    c.not_bit        = (opc == 12);
    c.carry_in       = (opc inside {2, 13});    // subtract style
    c.op2_complement = (opc inside {2, 13});
    c.shift_left     = (opc == 6);
    c.compare        = (opc == 13);
    c.logic_op       = (opc inside {3, 4, 5, 10, 11, 12});
    c.jump           = (opc inside {7, 14, 15, 16, 17});
    c.jmp_uncond     = (opc == 7);
    c.jmp_gt         = (opc == 14);
    c.jmp_lt         = (opc == 15);
    c.jmp_eq         = (opc == 16);
    c.jmp_carry      = (opc == 17);
    c.load           = (opc == 8);
    c.store          = (opc == 9);
    c.ld_imm         = (opc == 18);
    c.out_op         = (opc == 26);
    c.in_op          = (opc == 27);
    c.wr_en          = alu || (opc inside {8, 18, 27});
    c.dest           = (opc == 9) ? '0 : ins[10:8];
    c.imm            = ins[7:0];
    c.target         = ins[9:0];
    q.rd_en    = rd_ab || rd_c;
    q.op1_addr = rd_ab ? ins[2:0] : '0;
    q.op2_addr = rd_ab ? ins[6:4] : '0;
    q.op3_addr = rd_c ? ins[10:8] : '0;
endfunction

`endif

// File: dv/ifid_tb.sv
// random decode traffic against a reference model at one item per clock
// register file is a combinational stub keyed on the read addresses
// stops at the first mismatch
`default_nettype none

`include "ifid_config.svh"

module ifid_tb;

    `include "ifid_tb_model.svh"

    localparam int ITEMS          = 2000;
    localparam int RESET_WAIT_MAX = 64;         // cycles
    localparam int ITEM_WAIT_MAX  = ITEMS + 16;

    typedef struct packed {
        ifid_pkg::ctrl_t    ctrl;
        ifid_pkg::operand_t opnd;
        logic               squash;
    } expect_t;

    logic                     clk = 1'b0;
    logic                     rst;
    logic [`IFID_INSTR_W-1:0] instr;
    logic                     branch_taken_ex;
    ifid_pkg::operand_t       rd_data;
    ifid_pkg::rd_req_t        rd_req;
    logic                     load_req;
    ifid_pkg::ctrl_t          id_ctrl;
    ifid_pkg::operand_t       id_opnd;
    logic                     id_squash;

    logic    rst_seen   = 1'b1;     // rst as seen by the last rising edge
    int      seed       = 32'h163c6c45;
    int      items_done = 0;
    expect_t exp_q[$];              // one item in flight

    // nop plus every kept opcode picked most of the time
    logic [`IFID_OPC_W-1:0] kept_opc [0:20] = '{
        5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10,
        5'd11, 5'd12, 5'd13, 5'd14, 5'd15, 5'd16, 5'd17, 5'd18, 5'd26, 5'd27
    };

    always #2 clk = ~clk;

    always @(posedge clk)
        rst_seen <= rst;

    always_comb
        rd_data = regfile_read(rd_req);     // same-cycle regfile

    ifid_stage u_ifid_stage (
        .instr           (instr),
        .clk             (clk),
        .rst             (rst),
        .branch_taken_ex (branch_taken_ex),
        .rd_data         (rd_data),
        .rd_req          (rd_req),
        .load_req        (load_req),
        .id_ctrl         (id_ctrl),
        .id_opnd         (id_opnd),
        .id_squash       (id_squash)
    );

    bind ifid_stage ifid_chk u_ifid_chk (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .id_ctrl   (id_ctrl),
        .id_opnd   (id_opnd),
        .id_squash (id_squash)
    );

    //////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////
    task automatic abort_run(input string why);
        if (why != "")
            $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [63:0] got,
            input logic [63:0] want);
        if (got !== want)
        begin
            $display("FAILED time %0t signal %s got %h expected %h",
                     $time, name, got, want);
            abort_run("");
        end
    endtask

    // new instr and branch level then the same-cycle read request check
    task automatic drive_item();
        logic [31:0]       r;
        logic [4:0]        opc;
        int                idx;
        ifid_pkg::ctrl_t   c;
        ifid_pkg::rd_req_t q;
        expect_t           e;
        r   = $random(seed);
        idx = $unsigned($random(seed)) % 21;
        opc = (r[31:29] != 3'd0) ? kept_opc[idx] : r[20:16];   // 1/8 any code
        instr           = {opc, r[10:0]};
        branch_taken_ex = (r[27:25] == 3'd0);
        #1;
        model_decode(instr, c, q);
        check_eq("rd_req", 64'(rd_req), 64'(q));
        check_eq("load_req", 64'(load_req), 64'(c.load));
        e.ctrl   = branch_taken_ex ? '0 : c;
        e.opnd   = branch_taken_ex ? '0 : expected_operands(q);
        e.squash = branch_taken_ex;
        exp_q.push_back(e);
    endtask

    // check what the last rising edge captured and drive the next item
    task automatic step_cycle();
        expect_t e;
        bit      have;
        @(negedge clk);
        have = (exp_q.size() != 0);
        if (have)
            e = exp_q.pop_front();
        if (rst_seen)
        begin
            check_eq("id_ctrl", 64'(id_ctrl), 64'd0);
            check_eq("id_opnd", 64'(id_opnd), 64'd0);
            check_eq("id_squash", 64'(id_squash), 64'd0);
        end
        else if (have)
        begin
            check_eq("id_ctrl", 64'(id_ctrl), 64'(e.ctrl));
            check_eq("id_opnd", 64'(id_opnd), 64'(e.opnd));
            check_eq("id_squash", 64'(id_squash), 64'(e.squash));
            items_done++;
        end
        if (u_ifid_stage.u_ifid_chk.any_fired)
            abort_run("an assertion on the DUT outputs fired");
        drive_item();
    endtask

    //////////////////////////////////////////////////
    // reset and main sequence
    //////////////////////////////////////////////////
    initial
    begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    initial
    begin
        int n;
        instr           = '0;
        branch_taken_ex = 1'b0;
        n = 0;
        while (rst_seen)            // random traffic under reset too
        begin
            step_cycle();
            n++;
            if (n > RESET_WAIT_MAX)
                abort_run("reset was never released");
        end
        n = 0;
        while (items_done < ITEMS)
        begin
            step_cycle();
            n++;
            if (n > ITEM_WAIT_MAX)
                abort_run("items stopped arriving at the stage outputs");
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/ifid_pkg.sv
design/ifid_decoder.sv
design/ifid_stage_reg.sv
design/ifid_stage.sv
dv/ifid_chk.sv
dv/ifid_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := ifid_tb
RTL_TOP    := ifid_stage
FLIST      := flist.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
PASS_MSG   := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# pass only if the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
